/* Bender.yml */
package:
  name: rv_two_stage

sources:
  - rvPkg.sv
  - fetchUnit.sv
  - ifIdReg.sv
  - decoder.sv
  - regFile.sv
  - execUnit.sv
  - cpuTop.sv
  - target: simulation
    files:
      - cpu_checker.sv
      - cpuTb.sv

/* cpuTb.sv */
// cpuTb: directed testbench running hand-encoded programs on the two-stage core
module cpuTb;
  timeunit 1ns;
  timeprecision 1ps;
  import rvPkg::*;

  localparam int haltTimeout = 200;

  logic   clk;
  logic   rstN;
  logic   progWe;
  wordT   progAddr;
  instT   progData;
  regIdxT dbgAddr;
  wordT   dbgData;
  logic   halted;
  logic   illegalInst;

  int          errors;
  int          checks;
  logic [31:0] lfsr;
  instT        prog[$];

  cpuTop #(
    .imemWords (64),
    .dmemWords (64)
  ) DUT (
    .clk         (clk),
    .rstN        (rstN),
    .progWe      (progWe),
    .progAddr    (progAddr),
    .progData    (progData),
    .dbgAddr     (dbgAddr),
    .dbgData     (dbgData),
    .halted      (halted),
    .illegalInst (illegalInst)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic drawBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic wordT sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // field order follows the RV32I formats
  function automatic instT addi(input regIdxT rd, input regIdxT rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, opOpImm};
  endfunction

  function automatic instT rType(input logic [6:0] f7, input logic [2:0] f3, input regIdxT rd,
                                 input regIdxT rs1, input regIdxT rs2);
    return {f7, rs2, rs1, f3, rd, opOp};
  endfunction

  function automatic instT lui(input regIdxT rd, input logic [19:0] upper);
    return {upper, rd, opLui};
  endfunction

  function automatic instT load(input regIdxT rd, input regIdxT rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, opLoad};
  endfunction

  function automatic instT store(input regIdxT rs2, input regIdxT rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
  endfunction

  function automatic instT branch(input logic [2:0] f3, input regIdxT rs1, input regIdxT rs2,
                                  input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
  endfunction

  function automatic instT jump(input regIdxT rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
  endfunction

  task automatic checkWord(input string name, input wordT exp, input wordT act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
    end
  endtask

  // debug port is combinational so sample half a cycle later
  task automatic checkReg(input string name, input regIdxT idx, input wordT exp);
    @(posedge clk);
    dbgAddr <= idx;
    @(negedge clk);
    checkWord($sformatf("%s x%0d", name, idx), exp, dbgData);
  endtask

  // load prog under reset, release, then wait for the core to stop
  task automatic runProgram(input string name, input logic expIllegal);
    int cycles;
    @(posedge clk);
    rstN   <= 1'b0;
    progWe <= 1'b0;
    foreach (prog[i]) begin
      @(posedge clk);
      progWe   <= 1'b1;
      progAddr <= wordT'(i);
      progData <= prog[i];
    end
    @(posedge clk);
    progWe <= 1'b0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (halted !== 1'b1 && cycles < haltTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (halted !== 1'b1) begin
      errors++;
      $display("%s: core did not halt within %0d cycles", name, haltTimeout);
    end
    checkFlag({name, " illegalInst"}, expIllegal, illegalInst);
  endtask

  task automatic testArith();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] u;
    wordT        av;
    wordT        bv;
    drawBits(12, a);
    drawBits(12, b);
    drawBits(20, u);
    av = sext12(a[11:0]);
    bv = sext12(b[11:0]);
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, a[11:0]));
    prog.push_back(addi(5'd2, 5'd0, b[11:0]));
    prog.push_back(addi(5'd3, 5'd1, b[11:0]));
    prog.push_back(rType(7'b0000000, 3'b000, 5'd4, 5'd1, 5'd2));
    prog.push_back(rType(7'b0100000, 3'b000, 5'd5, 5'd1, 5'd2));
    prog.push_back(rType(7'b0000000, 3'b111, 5'd6, 5'd1, 5'd2));
    prog.push_back(rType(7'b0000000, 3'b110, 5'd7, 5'd1, 5'd2));
    prog.push_back(rType(7'b0000000, 3'b100, 5'd8, 5'd1, 5'd2));
    prog.push_back(lui(5'd9, u[19:0]));
    prog.push_back(32'h0010_0073);
    runProgram("arith", 1'b0);
    checkReg("arith addi", 5'd1, av);
    checkReg("arith addi", 5'd2, bv);
    checkReg("arith addi", 5'd3, av + bv);
    checkReg("arith add", 5'd4, av + bv);
    checkReg("arith sub", 5'd5, av - bv);
    checkReg("arith and", 5'd6, av & bv);
    checkReg("arith or", 5'd7, av | bv);
    checkReg("arith xor", 5'd8, av ^ bv);
    checkReg("arith lui", 5'd9, {u[19:0], 12'h000});
  endtask

  task automatic testBranch();
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd5));
    prog.push_back(addi(5'd2, 5'd0, 12'd5));
    prog.push_back(addi(5'd3, 5'd0, 12'd7));
    for (int r = 10; r < 15; r++) begin
      prog.push_back(addi(regIdxT'(r), 5'd0, 12'd0));
    end
    // two taken, each skipping one addi, then two not taken
    prog.push_back(branch(3'b000, 5'd1, 5'd2, 13'd8));
    prog.push_back(addi(5'd10, 5'd0, 12'd1));
    prog.push_back(branch(3'b001, 5'd1, 5'd3, 13'd8));
    prog.push_back(addi(5'd11, 5'd0, 12'd1));
    prog.push_back(branch(3'b000, 5'd1, 5'd3, 13'd8));
    prog.push_back(addi(5'd12, 5'd0, 12'd3));
    prog.push_back(branch(3'b001, 5'd1, 5'd2, 13'd8));
    prog.push_back(addi(5'd13, 5'd0, 12'd4));
    prog.push_back(addi(5'd14, 5'd0, 12'd9));
    prog.push_back(32'h0010_0073);
    runProgram("branch", 1'b0);
    checkReg("branch beq taken", 5'd10, 32'd0);
    checkReg("branch bne taken", 5'd11, 32'd0);
    checkReg("branch beq not taken", 5'd12, 32'd3);
    checkReg("branch bne not taken", 5'd13, 32'd4);
    checkReg("branch target path", 5'd14, 32'd9);
  endtask

  task automatic testJump();
    prog.delete();
    prog.push_back(addi(5'd5, 5'd0, 12'd0));
    prog.push_back(addi(5'd6, 5'd0, 12'd0));
    prog.push_back(jump(5'd1, 21'd12));
    prog.push_back(addi(5'd5, 5'd0, 12'd1));
    prog.push_back(addi(5'd5, 5'd0, 12'd2));
    prog.push_back(addi(5'd6, 5'd0, 12'd6));
    prog.push_back(32'h0010_0073);
    runProgram("jal", 1'b0);
    // jal sits at pc 8
    checkReg("jal link", 5'd1, 32'd12);
    checkReg("jal skipped", 5'd5, 32'd0);
    checkReg("jal target", 5'd6, 32'd6);
  endtask

  task automatic testMemory();
    logic [31:0] v [4];
    logic [11:0] off [4];
    off[0] = 12'h000;
    off[1] = 12'h004;
    off[2] = 12'h00c;
    off[3] = 12'hffc;
    for (int i = 0; i < 4; i++) begin
      drawBits(12, v[i]);
    end
    prog.delete();
    prog.push_back(addi(5'd10, 5'd0, 12'd16));
    for (int i = 0; i < 4; i++) begin
      prog.push_back(addi(regIdxT'(i + 1), 5'd0, v[i][11:0]));
      prog.push_back(store(regIdxT'(i + 1), 5'd10, off[i]));
    end
    for (int i = 0; i < 4; i++) begin
      prog.push_back(load(regIdxT'(i + 11), 5'd10, off[i]));
    end
    prog.push_back(32'h0010_0073);
    runProgram("memory", 1'b0);
    for (int i = 0; i < 4; i++) begin
      checkReg("memory lw", regIdxT'(i + 11), sext12(v[i][11:0]));
    end
  endtask

  task automatic testHalt();
    prog.delete();
    prog.push_back(addi(5'd7, 5'd0, 12'd11));
    prog.push_back(addi(5'd8, 5'd0, 12'd0));
    // custom-0 opcode is outside the subset
    prog.push_back(32'h0000_000b);
    prog.push_back(addi(5'd8, 5'd0, 12'd22));
    prog.push_back(32'h0010_0073);
    runProgram("illegal", 1'b1);
    checkReg("illegal before", 5'd7, 32'd11);
    checkReg("illegal after", 5'd8, 32'd0);
    prog.delete();
    prog.push_back(addi(5'd9, 5'd0, 12'd33));
    prog.push_back(32'h0010_0073);
    prog.push_back(addi(5'd9, 5'd0, 12'd44));
    runProgram("ebreak", 1'b0);
    checkReg("ebreak", 5'd9, 32'd33);
  endtask

  task automatic testZero();
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd55));
    prog.push_back(addi(5'd0, 5'd0, 12'd123));
    prog.push_back(rType(7'b0000000, 3'b000, 5'd0, 5'd1, 5'd1));
    prog.push_back(rType(7'b0000000, 3'b000, 5'd3, 5'd0, 5'd1));
    prog.push_back(rType(7'b0100000, 3'b000, 5'd4, 5'd0, 5'd1));
    prog.push_back(32'h0010_0073);
    runProgram("zero", 1'b0);
    checkReg("zero write", 5'd0, 32'd0);
    checkReg("zero source add", 5'd3, 32'd55);
    checkReg("zero source sub", 5'd4, 32'd0 - 32'd55);
  endtask

  initial begin
    errors   = 0;
    checks   = 0;
    lfsr     = 32'h6baf_eae8;
    rstN     = 1'b0;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    dbgAddr  = '0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    testArith();
    testBranch();
    testJump();
    testMemory();
    testHalt();
    testZero();
    errors += DUT.statusChecks.assertFails;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* cpuTop.sv */
// cpuTop: two-stage core built from fetch, the IF/ID register and the execute stage
module cpuTop #(
  parameter int imemWords = 64,
  parameter int dmemWords = 64
) (
  input  logic           clk,
  input  logic           rstN,
  input  logic           progWe,
  input  rvPkg::wordT    progAddr,
  input  rvPkg::instT    progData,
  input  rvPkg::regIdxT  dbgAddr,
  output rvPkg::wordT    dbgData,
  output logic           halted,
  output logic           illegalInst
);
  import rvPkg::*;

  fetchT    ifFetch;
  fetchT    exFetch;
  redirectT redirect;

  fetchUnit #(
    .imemWords (imemWords)
  ) u_fetchUnit (
    .clk      (clk),
    .rstN     (rstN),
    .progWe   (progWe),
    .progAddr (progAddr),
    .progData (progData),
    .halted   (halted),
    .redirect (redirect),
    .fetch    (ifFetch)
  );

  // a taken redirect squashes the word fetched alongside it
  ifIdReg u_ifIdReg (
    .clk      (clk),
    .rstN     (rstN),
    .fetchIn  (ifFetch),
    .flush    (redirect.taken),
    .fetchOut (exFetch)
  );

  execUnit #(
    .dmemWords (dmemWords)
  ) u_execUnit (
    .clk         (clk),
    .rstN        (rstN),
    .stage       (exFetch),
    .dbgAddr     (dbgAddr),
    .dbgData     (dbgData),
    .redirect    (redirect),
    .halted      (halted),
    .illegalInst (illegalInst)
  );

endmodule

/* cpu_checker.sv */
// cpuChecker: concurrent assertions on the halted and illegalInst status outputs
module cpuChecker (
  input logic clk,
  input logic rstN,
  input logic halted,
  input logic illegalInst
);
  timeunit 1ns;
  timeprecision 1ps;

  int assertFails = 0;

  // first sampled cycle out of reset must still be running
  runAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !halted)
    else begin
      assertFails++;
      $error("halted is high in the first cycle after reset");
    end

  // halt only clears through reset
  haltSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
    else begin
      assertFails++;
      $error("halted dropped without a reset");
    end

  illegalHalts: assert property (@(posedge clk) disable iff (!rstN) illegalInst |-> halted)
    else begin
      assertFails++;
      $error("illegalInst is high while the core is not halted");
    end

endmodule

bind cpuTop cpuChecker statusChecks (
  .clk         (clk),
  .rstN        (rstN),
  .halted      (halted),
  .illegalInst (illegalInst)
);

/* decoder.sv */
// decoder: maps an RV32I subset instruction to control bits and its immediate
module decoder (
  input  rvPkg::instT    inst,
  output rvPkg::ctrlT    ctrl,
  output rvPkg::wordT    imm,
  output rvPkg::regIdxT  rs1,
  output rvPkg::regIdxT  rs2,
  output rvPkg::regIdxT  rd
);
  import rvPkg::*;

  localparam instT ebreakInst = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  wordT       iImm;
  wordT       sImm;
  wordT       bImm;
  wordT       uImm;
  wordT       jImm;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];

  // sign-extended immediate formats
  assign iImm = {{20{inst[31]}}, inst[31:20]};
  assign sImm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign bImm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign uImm = {inst[31:12], 12'b0};
  assign jImm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = aluAdd;
    imm        = iImm;
    case (opcode)
      opOpImm: begin
        // only ADDI in this subset
        ctrl.useImm    = 1'b1;
        ctrl.regWen    = (funct3 == 3'b000);
        ctrl.isIllegal = (funct3 != 3'b000);
      end
      opOp: begin
        case ({funct7, funct3})
          10'b0000000_000: ctrl.aluOp = aluAdd;
          10'b0100000_000: ctrl.aluOp = aluSub;
          10'b0000000_100: ctrl.aluOp = aluXor;
          10'b0000000_110: ctrl.aluOp = aluOr;
          10'b0000000_111: ctrl.aluOp = aluAnd;
          default:         ctrl.isIllegal = 1'b1;
        endcase
        ctrl.regWen = !ctrl.isIllegal;
      end
      opLui: begin
        imm         = uImm;
        ctrl.aluOp  = aluPassB;
        ctrl.useImm = 1'b1;
        ctrl.regWen = 1'b1;
      end
      opBranch: begin
        imm = bImm;
        case (funct3)
          3'b000:  ctrl.aluOp = aluEq;
          3'b001:  ctrl.aluOp = aluNe;
          default: ctrl.isIllegal = 1'b1;
        endcase
        ctrl.isBranch = !ctrl.isIllegal;
      end
      opJal: begin
        imm         = jImm;
        ctrl.isJal  = 1'b1;
        ctrl.regWen = 1'b1;
      end
      opLoad: begin
        // word loads only
        ctrl.useImm    = 1'b1;
        ctrl.isLoad    = (funct3 == 3'b010);
        ctrl.regWen    = (funct3 == 3'b010);
        ctrl.isIllegal = (funct3 != 3'b010);
      end
      opStore: begin
        imm            = sImm;
        ctrl.useImm    = 1'b1;
        ctrl.memWen    = (funct3 == 3'b010);
        ctrl.isIllegal = (funct3 != 3'b010);
      end
      opSystem: begin
        ctrl.isEbreak  = (inst == ebreakInst);
        ctrl.isIllegal = (inst != ebreakInst);
      end
      default: ctrl.isIllegal = 1'b1;
    endcase
  end

endmodule

/* execUnit.sv */
// execUnit: decode, register read, ALU, data memory, writeback and run/halt control
module execUnit #(
  parameter int dmemWords = 64
) (
  input  logic             clk,
  input  logic             rstN,
  input  rvPkg::fetchT     stage,
  input  rvPkg::regIdxT    dbgAddr,
  output rvPkg::wordT      dbgData,
  output rvPkg::redirectT  redirect,
  output logic             halted,
  output logic             illegalInst
);
  import rvPkg::*;

  localparam int dmemAw = $clog2(dmemWords);

  ctrlT             ctrl;
  wordT             imm;
  regIdxT           rs1;
  regIdxT           rs2;
  regIdxT           rd;
  wordT             rdataA;
  wordT             rdataB;
  wordT             opB;
  wordT             aluResult;
  wordT             loadData;
  wordT             wbData;
  logic [dmemAw-1:0] dmemIdx;
  logic             active;
  coreStateE        state;
  wordT             dmem [dmemWords];

  decoder u_decoder (
    .inst (stage.inst),
    .ctrl (ctrl),
    .imm  (imm),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd)
  );

  // a bubble or a halted core does nothing
  assign active = stage.valid && (state == coreRun);

  regFile u_regFile (
    .clk     (clk),
    .wen     (active && ctrl.regWen),
    .waddr   (rd),
    .wdata   (wbData),
    .raddrA  (rs1),
    .raddrB  (rs2),
    .dbgAddr (dbgAddr),
    .rdataA  (rdataA),
    .rdataB  (rdataB),
    .dbgData (dbgData)
  );

  assign opB = ctrl.useImm ? imm : rdataB;

  always_comb begin
    case (ctrl.aluOp)
      aluAdd:   aluResult = rdataA + opB;
      aluSub:   aluResult = rdataA - opB;
      aluAnd:   aluResult = rdataA & opB;
      aluOr:    aluResult = rdataA | opB;
      aluXor:   aluResult = rdataA ^ opB;
      aluPassB: aluResult = opB;
      aluEq:    aluResult = {31'd0, rdataA == opB};
      default:  aluResult = {31'd0, rdataA != opB};
    endcase
  end

  // branch target and jump target share pc + imm
  assign redirect.taken  = active && (ctrl.isJal || (ctrl.isBranch && aluResult[0]));
  assign redirect.target = stage.pc + imm;

  // word-addressed data memory
  assign dmemIdx  = aluResult[dmemAw+1:2];
  assign loadData = dmem[dmemIdx];

  always_ff @(posedge clk) begin
    if (active && ctrl.memWen) begin
      dmem[dmemIdx] <= rdataB;
    end
  end

  assign wbData = ctrl.isJal  ? stage.pc + 32'd4 :
                  ctrl.isLoad ? loadData : aluResult;

  // halt holds until reset and the illegal flag is sticky
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state       <= coreRun;
      illegalInst <= 1'b0;
    end else if (active && (ctrl.isEbreak || ctrl.isIllegal)) begin
      state       <= coreHalt;
      illegalInst <= illegalInst | ctrl.isIllegal;
    end
  end

  assign halted = (state == coreHalt);

endmodule

/* fetchUnit.sv */
// fetchUnit: program counter and instruction memory, with redirect and halt handling
module fetchUnit #(
  parameter int imemWords = 64
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             progWe,
  input  rvPkg::wordT      progAddr,
  input  rvPkg::instT      progData,
  input  logic             halted,
  input  rvPkg::redirectT  redirect,
  output rvPkg::fetchT     fetch
);
  import rvPkg::*;

  localparam int imemAw = $clog2(imemWords);

  wordT pc;
  instT imem [imemWords];

  // program port is live even while the core sits in reset
  always_ff @(posedge clk) begin
    if (progWe) begin
      imem[progAddr[imemAw-1:0]] <= progData;
    end
  end

  // halt wins, then a taken branch or jump, then sequential
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= resetPc;
    end else if (halted) begin
      pc <= pc;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // word-aligned async read at the current pc
  always_comb begin
    fetch.valid = !halted;
    fetch.pc    = pc;
    fetch.inst  = imem[pc[imemAw+1:2]];
  end

endmodule

/* ifIdReg.sv */
// ifIdReg: IF/ID pipeline register that turns into a bubble on reset or flush
module ifIdReg (
  input  logic          clk,
  input  logic          rstN,
  input  rvPkg::fetchT  fetchIn,
  input  logic          flush,
  output rvPkg::fetchT  fetchOut
);

  // only the valid bit decides whether stage two acts
  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      fetchOut.valid <= 1'b0;
    end else begin
      fetchOut.valid <= fetchIn.valid;
    end
  end

  // payload follows fetch every cycle
  always_ff @(posedge clk) begin
    fetchOut.pc   <= fetchIn.pc;
    fetchOut.inst <= fetchIn.inst;
  end

endmodule

/* regFile.sv */
// regFile: 32 x 32 register file with two operand reads, a debug read and x0 tied to zero
module regFile (
  input  logic           clk,
  input  logic           wen,
  input  rvPkg::regIdxT  waddr,
  input  rvPkg::wordT    wdata,
  input  rvPkg::regIdxT  raddrA,
  input  rvPkg::regIdxT  raddrB,
  input  rvPkg::regIdxT  dbgAddr,
  output rvPkg::wordT    rdataA,
  output rvPkg::wordT    rdataB,
  output rvPkg::wordT    dbgData
);

  logic [31:0] regs [32];

  // x0 is never stored, so its slot stays unwritten
  always_ff @(posedge clk) begin
    if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads as zero on every port
  assign rdataA  = (raddrA == 5'd0) ? 32'd0 : regs[raddrA];
  assign rdataB  = (raddrB == 5'd0) ? 32'd0 : regs[raddrB];
  assign dbgData = (dbgAddr == 5'd0) ? 32'd0 : regs[dbgAddr];

endmodule

/* rvPkg.sv */
// rvPkg: shared widths, opcodes, enums and pipeline structs for the two-stage RV32I core
package rvPkg;

  typedef logic [31:0] wordT;
  typedef logic [31:0] instT;
  typedef logic [4:0]  regIdxT;

  // compares return a single bit in the result LSB
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluPassB,
    aluEq,
    aluNe
  } aluOpE;

  typedef enum logic {
    coreRun,
    coreHalt
  } coreStateE;

  // valid low marks a bubble
  typedef struct packed {
    logic valid;
    wordT pc;
    instT inst;
  } fetchT;

  typedef struct packed {
    aluOpE aluOp;
    logic  useImm;
    logic  regWen;
    logic  memWen;
    logic  isLoad;
    logic  isBranch;
    logic  isJal;
    logic  isEbreak;
    logic  isIllegal;
  } ctrlT;

  typedef struct packed {
    logic taken;
    wordT target;
  } redirectT;

  // major opcodes of the supported subset
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opSystem = 7'b1110011;

  localparam wordT resetPc = 32'h0000_0000;

endpackage

/* sim.f */
rvPkg.sv
fetchUnit.sv
ifIdReg.sv
decoder.sv
regFile.sv
execUnit.sv
cpuTop.sv
cpu_checker.sv
cpuTb.sv
